// ==== hdl/mips_exec_settings.svh ====
`ifndef MIPS_EXEC_SETTINGS_SVH
`define MIPS_EXEC_SETTINGS_SVH

// datapath word
`define MIPS_XLEN 32

// register file geometry
`define MIPS_REG_COUNT 32
`define MIPS_REG_IDX_W 5

// exception cause codes
`define MIPS_CAUSE_W 5
`define MIPS_CAUSE_RI 5'd10
`define MIPS_CAUSE_OV 5'd12

`endif

// ==== hdl/mips_pkg.sv ====
`include "mips_exec_settings.svh"

package mips_pkg;

    typedef struct packed {
        logic [5:0]                 opcode;
        logic [`MIPS_REG_IDX_W-1:0] rs;
        logic [`MIPS_REG_IDX_W-1:0] rt;
        logic [`MIPS_REG_IDX_W-1:0] rd;
        logic [4:0]                 shamt;
        logic [5:0]                 funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]                 opcode;
        logic [`MIPS_REG_IDX_W-1:0] rs;
        logic [`MIPS_REG_IDX_W-1:0] rt;
        logic [15:0]                imm16;
    } i_fields_t;

    // same instruction word, two field layouts
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_PLUS,
        ALU_MINUS,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI
    } alu_op_t;

    typedef enum logic {
        SHIFT_SHAMT,
        SHIFT_REG
    } shift_src_t;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDI    = 6'h08;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // SPECIAL funct codes
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_SLLV = 6'h04;
    localparam logic [5:0] FN_SRLV = 6'h06;
    localparam logic [5:0] FN_SRAV = 6'h07;
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

endpackage

// ==== hdl/reg_file.sv ====
`timescale 1ns/10ps
`include "mips_exec_settings.svh"

module reg_file (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic [`MIPS_REG_IDX_W-1:0] ra1,
    input  logic [`MIPS_REG_IDX_W-1:0] ra2,
    output logic [`MIPS_XLEN-1:0]      rd1,
    output logic [`MIPS_XLEN-1:0]      rd2,
    input  logic                       we,
    input  logic [`MIPS_REG_IDX_W-1:0] wa,
    input  logic [`MIPS_XLEN-1:0]      wd
);

    logic [`MIPS_XLEN-1:0] regs [`MIPS_REG_COUNT];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int n = 0; n < `MIPS_REG_COUNT; n++) begin
                regs[n] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // $zero is hardwired
    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/10ps
`include "mips_exec_settings.svh"

module decode_stage (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       instr_valid,
    input  mips_pkg::instr_t           instr,
    input  logic [`MIPS_XLEN-1:0]      rd1,
    input  logic [`MIPS_XLEN-1:0]      rd2,
    input  logic                       fwd_e_en,
    input  logic [`MIPS_REG_IDX_W-1:0] fwd_e_dest,
    input  logic [`MIPS_XLEN-1:0]      fwd_e_data,
    input  logic                       wb_valid,
    input  logic [`MIPS_REG_IDX_W-1:0] wb_reg,
    input  logic [`MIPS_XLEN-1:0]      wb_data,
    output logic [`MIPS_REG_IDX_W-1:0] ra1,
    output logic [`MIPS_REG_IDX_W-1:0] ra2,
    output logic                       e_valid,
    output mips_pkg::alu_op_t          e_op,
    output mips_pkg::shift_src_t       e_shift_src,
    output logic [4:0]                 e_shamt,
    output logic [`MIPS_XLEN-1:0]      e_src_a,
    output logic [`MIPS_XLEN-1:0]      e_src_b,
    output logic [`MIPS_REG_IDX_W-1:0] e_dest,
    output logic                       e_write,
    output logic                       e_trap_ov,
    output logic                       e_ri
);

    logic                       d_valid;
    mips_pkg::instr_t           d_instr;
    mips_pkg::alu_op_t          dec_op;
    mips_pkg::shift_src_t       dec_shift_src;
    logic                       dec_use_imm;
    logic                       dec_sign_ext;
    logic                       dec_dest_rd;
    logic                       dec_trap_ov;
    logic                       dec_ri;
    logic [`MIPS_REG_IDX_W-1:0] dec_dest;
    logic [`MIPS_XLEN-1:0]      imm_ext;
    logic [`MIPS_XLEN-1:0]      fwd_a;
    logic [`MIPS_XLEN-1:0]      fwd_b;

    // youngest producer wins: execute, then writeback, then regfile
    function automatic logic [`MIPS_XLEN-1:0] pick_src(
        input logic [`MIPS_REG_IDX_W-1:0] idx,
        input logic [`MIPS_XLEN-1:0]      rf_val
    );
        if (fwd_e_en && fwd_e_dest == idx) begin
            return fwd_e_data;
        end else if (wb_valid && wb_reg == idx) begin
            return wb_data;
        end
        return rf_val;
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            d_instr <= instr;
        end
    end

    always_comb begin
        dec_op        = mips_pkg::ALU_PLUS;
        dec_shift_src = mips_pkg::SHIFT_SHAMT;
        dec_use_imm   = 1'b0;
        dec_sign_ext  = 1'b1;
        dec_dest_rd   = 1'b0;
        dec_trap_ov   = 1'b0;
        dec_ri        = 1'b0;
        if (d_instr.r.opcode == mips_pkg::OP_SPECIAL) begin
            dec_dest_rd = 1'b1;
            case (d_instr.r.funct)
                mips_pkg::FN_SLL:  dec_op = mips_pkg::ALU_SLL;
                mips_pkg::FN_SRL:  dec_op = mips_pkg::ALU_SRL;
                mips_pkg::FN_SRA:  dec_op = mips_pkg::ALU_SRA;
                mips_pkg::FN_SLLV: begin
                    dec_op        = mips_pkg::ALU_SLL;
                    dec_shift_src = mips_pkg::SHIFT_REG;
                end
                mips_pkg::FN_SRLV: begin
                    dec_op        = mips_pkg::ALU_SRL;
                    dec_shift_src = mips_pkg::SHIFT_REG;
                end
                mips_pkg::FN_SRAV: begin
                    dec_op        = mips_pkg::ALU_SRA;
                    dec_shift_src = mips_pkg::SHIFT_REG;
                end
                mips_pkg::FN_ADD:  dec_trap_ov = 1'b1;
                mips_pkg::FN_ADDU: dec_op = mips_pkg::ALU_PLUS;
                mips_pkg::FN_SUB: begin
                    dec_op      = mips_pkg::ALU_MINUS;
                    dec_trap_ov = 1'b1;
                end
                mips_pkg::FN_SUBU: dec_op = mips_pkg::ALU_MINUS;
                mips_pkg::FN_AND:  dec_op = mips_pkg::ALU_AND;
                mips_pkg::FN_OR:   dec_op = mips_pkg::ALU_OR;
                mips_pkg::FN_XOR:  dec_op = mips_pkg::ALU_XOR;
                mips_pkg::FN_NOR:  dec_op = mips_pkg::ALU_NOR;
                mips_pkg::FN_SLT:  dec_op = mips_pkg::ALU_SLT;
                mips_pkg::FN_SLTU: dec_op = mips_pkg::ALU_SLTU;
                default:           dec_ri = 1'b1;
            endcase
        end else begin
            dec_use_imm = 1'b1;
            case (d_instr.i.opcode)
                mips_pkg::OP_ADDI:  dec_trap_ov = 1'b1;
                mips_pkg::OP_ADDIU: dec_op = mips_pkg::ALU_PLUS;
                mips_pkg::OP_SLTI:  dec_op = mips_pkg::ALU_SLT;
                mips_pkg::OP_SLTIU: dec_op = mips_pkg::ALU_SLTU;
                mips_pkg::OP_ANDI: begin
                    dec_op       = mips_pkg::ALU_AND;
                    dec_sign_ext = 1'b0;
                end
                mips_pkg::OP_ORI: begin
                    dec_op       = mips_pkg::ALU_OR;
                    dec_sign_ext = 1'b0;
                end
                mips_pkg::OP_XORI: begin
                    dec_op       = mips_pkg::ALU_XOR;
                    dec_sign_ext = 1'b0;
                end
                mips_pkg::OP_LUI: begin
                    dec_op       = mips_pkg::ALU_LUI;
                    dec_sign_ext = 1'b0;
                end
                default: dec_ri = 1'b1;
            endcase
        end
    end

    assign ra1      = d_instr.r.rs;
    assign ra2      = d_instr.r.rt;
    assign dec_dest = dec_dest_rd ? d_instr.r.rd : d_instr.i.rt;
    assign imm_ext  = dec_sign_ext
                    ? {{(`MIPS_XLEN-16){d_instr.i.imm16[15]}}, d_instr.i.imm16}
                    : {{(`MIPS_XLEN-16){1'b0}}, d_instr.i.imm16};

    always_comb begin
        fwd_a = pick_src(ra1, rd1);
        fwd_b = pick_src(ra2, rd2);
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            e_valid <= 1'b0;
        end else begin
            e_valid <= d_valid;
        end
    end

    always_ff @(posedge clk) begin
        e_op        <= dec_op;
        e_shift_src <= dec_shift_src;
        e_shamt     <= d_instr.r.shamt;
        e_src_a     <= fwd_a;
        e_src_b     <= dec_use_imm ? imm_ext : fwd_b;
        e_dest      <= dec_dest;
        // writes to $zero are dropped here
        e_write     <= !dec_ri && dec_dest != '0;
        e_trap_ov   <= dec_trap_ov;
        e_ri        <= dec_ri;
    end

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/10ps
`include "mips_exec_settings.svh"

module execute_stage (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       e_valid,
    input  mips_pkg::alu_op_t          e_op,
    input  mips_pkg::shift_src_t       e_shift_src,
    input  logic [4:0]                 e_shamt,
    input  logic [`MIPS_XLEN-1:0]      e_src_a,
    input  logic [`MIPS_XLEN-1:0]      e_src_b,
    input  logic [`MIPS_REG_IDX_W-1:0] e_dest,
    input  logic                       e_write,
    input  logic                       e_trap_ov,
    input  logic                       e_ri,
    output logic                       fwd_e_en,
    output logic [`MIPS_REG_IDX_W-1:0] fwd_e_dest,
    output logic [`MIPS_XLEN-1:0]      fwd_e_data,
    output logic                       wb_valid,
    output logic [`MIPS_REG_IDX_W-1:0] wb_reg,
    output logic [`MIPS_XLEN-1:0]      wb_data,
    output logic                       exc_valid,
    output logic [`MIPS_CAUSE_W-1:0]   exc_cause
);

    logic [4:0]            shift_amt;
    logic [`MIPS_XLEN:0]   sum_ext;
    logic [`MIPS_XLEN-1:0] alu_res;
    logic                  ov_fault;

    assign shift_amt = (e_shift_src == mips_pkg::SHIFT_REG) ? e_src_a[4:0] : e_shamt;

    // one extra sign bit so overflow shows up as a mismatch of the top two
    always_comb begin
        if (e_op == mips_pkg::ALU_MINUS) begin
            sum_ext = {e_src_a[`MIPS_XLEN-1], e_src_a} - {e_src_b[`MIPS_XLEN-1], e_src_b};
        end else begin
            sum_ext = {e_src_a[`MIPS_XLEN-1], e_src_a} + {e_src_b[`MIPS_XLEN-1], e_src_b};
        end
    end

    assign ov_fault = e_trap_ov && (sum_ext[`MIPS_XLEN] != sum_ext[`MIPS_XLEN-1]);

    always_comb begin
        case (e_op)
            mips_pkg::ALU_PLUS,
            mips_pkg::ALU_MINUS: alu_res = sum_ext[`MIPS_XLEN-1:0];
            mips_pkg::ALU_AND:   alu_res = e_src_a & e_src_b;
            mips_pkg::ALU_OR:    alu_res = e_src_a | e_src_b;
            mips_pkg::ALU_XOR:   alu_res = e_src_a ^ e_src_b;
            mips_pkg::ALU_NOR:   alu_res = ~(e_src_a | e_src_b);
            mips_pkg::ALU_SLL:   alu_res = e_src_b << shift_amt;
            mips_pkg::ALU_SRL:   alu_res = e_src_b >> shift_amt;
            mips_pkg::ALU_SRA:   alu_res = $signed(e_src_b) >>> shift_amt;
            mips_pkg::ALU_SLT: begin
                alu_res = {{(`MIPS_XLEN-1){1'b0}}, $signed(e_src_a) < $signed(e_src_b)};
            end
            mips_pkg::ALU_SLTU: begin
                alu_res = {{(`MIPS_XLEN-1){1'b0}}, e_src_a < e_src_b};
            end
            // immediate goes to the upper half
            default:             alu_res = {e_src_b[15:0], 16'h0000};
        endcase
    end

    assign fwd_e_en   = e_valid && e_write && !ov_fault;
    assign fwd_e_dest = e_dest;
    assign fwd_e_data = alu_res;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid  <= 1'b0;
            exc_valid <= 1'b0;
        end else begin
            wb_valid  <= fwd_e_en;
            exc_valid <= e_valid && (e_ri || ov_fault);
        end
    end

    always_ff @(posedge clk) begin
        wb_reg    <= e_dest;
        wb_data   <= alu_res;
        exc_cause <= e_ri ? `MIPS_CAUSE_RI : `MIPS_CAUSE_OV;
    end

endmodule

// ==== hdl/mips_exec.sv ====
`timescale 1ns/10ps
`include "mips_exec_settings.svh"

module mips_exec (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       instr_valid,
    input  logic [`MIPS_XLEN-1:0]      instr,
    output logic                       wb_valid,
    output logic [`MIPS_REG_IDX_W-1:0] wb_reg,
    output logic [`MIPS_XLEN-1:0]      wb_data,
    output logic                       exc_valid,
    output logic [`MIPS_CAUSE_W-1:0]   exc_cause
);

    mips_pkg::instr_t           instr_word;
    logic [`MIPS_REG_IDX_W-1:0] ra1;
    logic [`MIPS_REG_IDX_W-1:0] ra2;
    logic [`MIPS_XLEN-1:0]      rd1;
    logic [`MIPS_XLEN-1:0]      rd2;
    logic                       e_valid;
    mips_pkg::alu_op_t          e_op;
    mips_pkg::shift_src_t       e_shift_src;
    logic [4:0]                 e_shamt;
    logic [`MIPS_XLEN-1:0]      e_src_a;
    logic [`MIPS_XLEN-1:0]      e_src_b;
    logic [`MIPS_REG_IDX_W-1:0] e_dest;
    logic                       e_write;
    logic                       e_trap_ov;
    logic                       e_ri;
    logic                       fwd_e_en;
    logic [`MIPS_REG_IDX_W-1:0] fwd_e_dest;
    logic [`MIPS_XLEN-1:0]      fwd_e_data;

    assign instr_word = instr;

    // writeback register feeds the regfile write port
    reg_file reg_file_inst (
        .clk    (clk),
        .resetn (resetn),
        .ra1    (ra1),
        .ra2    (ra2),
        .rd1    (rd1),
        .rd2    (rd2),
        .we     (wb_valid),
        .wa     (wb_reg),
        .wd     (wb_data)
    );

    decode_stage decode_stage_inst (
        .instr  (instr_word),
        .*
    );

    execute_stage execute_stage_inst (
        .*
    );

endmodule

// ==== dv/clock_gen.sv ====
`timescale 1ns/10ps

module clock_gen (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held low for ten rising edges
    initial begin
        resetn = 1'b0;
        repeat (10) @(posedge clk);
        #1 resetn = 1'b1;
    end

endmodule

// ==== dv/mips_exec_props.sv ====
`timescale 1ns/10ps
`include "mips_exec_settings.svh"

module mips_exec_props (
    input logic                       clk,
    input logic                       resetn,
    input logic                       wb_valid,
    input logic [`MIPS_REG_IDX_W-1:0] wb_reg,
    input logic                       exc_valid,
    input logic [`MIPS_CAUSE_W-1:0]   exc_cause
);

    wb_exc_exclusive: assert property (@(posedge clk) disable iff (!resetn)
        !(wb_valid && exc_valid))
        else $error("wb_valid and exc_valid high together");

    no_zero_write: assert property (@(posedge clk) disable iff (!resetn)
        wb_valid |-> wb_reg != '0)
        else $error("writeback to register 0");

    known_cause: assert property (@(posedge clk) disable iff (!resetn)
        exc_valid |-> (exc_cause == `MIPS_CAUSE_RI || exc_cause == `MIPS_CAUSE_OV))
        else $error("exception with unknown cause %0d", exc_cause);

    quiet_after_reset: assert property (@(posedge clk)
        !resetn |=> (!wb_valid && !exc_valid))
        else $error("output active in the cycle after reset");

endmodule

// ==== dv/wb_monitor.sv ====
`timescale 1ns/10ps
`include "mips_exec_settings.svh"

module wb_monitor (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       wb_valid,
    input  logic [`MIPS_REG_IDX_W-1:0] wb_reg,
    input  logic [`MIPS_XLEN-1:0]      wb_data,
    input  logic                       exc_valid,
    input  logic [`MIPS_CAUSE_W-1:0]   exc_cause,
    output logic                       done,
    output int                         pass_count,
    output int                         fail_count
);

    logic [8*24-1:0] test_names [$];
    logic [7:0]      exp_kind [$];
    int              exp_a [$];
    logic [31:0]     exp_val [$];
    int              exp_test [$];
    int              test_errs;

    task automatic load_expected();
        int              fd;
        int              n;
        int              a;
        logic [8*8-1:0]  tag;
        logic [8*8-1:0]  oc;
        logic [8*24-1:0] name;
        logic [31:0]     word;
        logic [31:0]     val;
        logic [8*96-1:0] line;
        fd = $fopen("dv/mips_exec_stim.txt", "r");
        if (fd == 0) begin
            $display("monitor cannot open the stimulus file");
            return;
        end
        while ($fgets(line, fd) > 0) begin
            n = $sscanf(line, "%s", tag);
            if (n == 1 && tag == "T") begin
                n = $sscanf(line, "%s %s", tag, name);
                test_names.push_back(name);
            end else if (n == 1 && tag == "I") begin
                n = $sscanf(line, "%s %h %s %d %h", tag, word, oc, a, val);
                // outcome N gives no output
                if (n == 5 && oc != "N") begin
                    exp_kind.push_back(oc[7:0]);
                    exp_a.push_back(a);
                    exp_val.push_back(val);
                    exp_test.push_back(test_names.size() - 1);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("error at %0t: %s expected %h actual %h", $time, name, exp_v, act_v);
            test_errs++;
        end
    endtask

    initial begin
        int  cycles;
        bit  found;
        int  t;
        done       = 1'b0;
        pass_count = 0;
        fail_count = 0;
        test_errs  = 0;
        load_expected();
        cycles = 0;
        while (resetn !== 1'b1 && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        for (int i = 0; i < exp_kind.size(); i++) begin
            t      = exp_test[i];
            found  = 1'b0;
            cycles = 0;
            while (!found && cycles < 100) begin
                @(negedge clk);
                if (wb_valid || exc_valid) begin
                    found = 1'b1;
                end else begin
                    cycles++;
                end
            end
            if (!found) begin
                $display("timeout in test %0s: no writeback or exception for 100 cycles",
                         test_names[t]);
                fail_count++;
                break;
            end
            if (exp_kind[i] == "W") begin
                check_value("wb_valid", 32'd1, {31'd0, wb_valid});
                check_value("exc_valid", 32'd0, {31'd0, exc_valid});
                check_value("wb_reg", 32'(exp_a[i]), 32'(wb_reg));
                check_value("wb_data", exp_val[i], wb_data);
            end else begin
                check_value("exc_valid", 32'd1, {31'd0, exc_valid});
                check_value("wb_valid", 32'd0, {31'd0, wb_valid});
                check_value("exc_cause", 32'(exp_a[i]), 32'(exc_cause));
            end
            // last checked entry closes the test
            if (i == exp_kind.size() - 1 || exp_test[i + 1] != t) begin
                if (test_errs == 0) begin
                    pass_count++;
                    $display("test %0s passed", test_names[t]);
                end else begin
                    fail_count++;
                    $display("test %0s failed with %0d errors", test_names[t], test_errs);
                end
                test_errs = 0;
            end
        end
        done = 1'b1;
    end

endmodule

// ==== dv/tb_mips_exec.sv ====
`timescale 1ns/10ps
`include "mips_exec_settings.svh"

module tb_mips_exec;

    logic                       clk;
    logic                       resetn;
    logic                       instr_valid;
    logic [`MIPS_XLEN-1:0]      instr;
    logic                       wb_valid;
    logic [`MIPS_REG_IDX_W-1:0] wb_reg;
    logic [`MIPS_XLEN-1:0]      wb_data;
    logic                       exc_valid;
    logic [`MIPS_CAUSE_W-1:0]   exc_cause;
    logic                       mon_done;
    int                         pass_count;
    int                         fail_count;
    bit                         run_ok;

    clock_gen clock_gen_inst (
        .clk    (clk),
        .resetn (resetn)
    );

    mips_exec mips_exec_inst (
        .clk         (clk),
        .resetn      (resetn),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data),
        .exc_valid   (exc_valid),
        .exc_cause   (exc_cause)
    );

    wb_monitor wb_monitor_inst (
        .clk        (clk),
        .resetn     (resetn),
        .wb_valid   (wb_valid),
        .wb_reg     (wb_reg),
        .wb_data    (wb_data),
        .exc_valid  (exc_valid),
        .exc_cause  (exc_cause),
        .done       (mon_done),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    bind mips_exec mips_exec_props mips_exec_props_inst (.*);

    task automatic drive_slot(input logic valid, input logic [31:0] word);
        @(posedge clk);
        #1;
        instr_valid = valid;
        instr       = word;
    endtask

    initial begin
        int              fd;
        int              n;
        int              cycles;
        logic [8*8-1:0]  tag;
        logic [31:0]     word;
        logic [8*96-1:0] line;
        instr_valid = 1'b0;
        instr       = '0;
        run_ok      = 1'b1;
        cycles = 0;
        while (resetn !== 1'b1 && cycles < 100) begin
            @(posedge clk);
            cycles++;
        end
        if (resetn !== 1'b1) begin
            $display("reset was never released");
            run_ok = 1'b0;
        end
        fd = $fopen("dv/mips_exec_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file");
            run_ok = 1'b0;
        end else begin
            while ($fgets(line, fd) > 0) begin
                n = $sscanf(line, "%s %h", tag, word);
                if (n == 2 && tag == "I") begin
                    drive_slot(1'b1, word);
                end else if (n >= 1 && tag == "B") begin
                    drive_slot(1'b0, '0);
                end
            end
            $fclose(fd);
        end
        drive_slot(1'b0, '0);
        cycles = 0;
        while (!mon_done && cycles < 1000) begin
            @(posedge clk);
            cycles++;
        end
        if (!mon_done) begin
            $display("monitor did not finish within 1000 cycles");
            run_ok = 1'b0;
        end
        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (run_ok && fail_count == 0 && pass_count > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== mips_exec.f ====
+incdir+hdl
hdl/mips_pkg.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mips_exec.sv
dv/clock_gen.sv
dv/mips_exec_props.sv
dv/wb_monitor.sv
dv/tb_mips_exec.sv

// ==== run.sh ====
#!/bin/bash
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mips_exec -f mips_exec.f -o tb_mips_exec_sim || exit 1

out="$(./obj_dir/tb_mips_exec_sim)"
echo "$out"
echo "$out" | grep -q "Test completed successfully" && exit 0 || exit 1

// ==== dv/mips_exec_stim.txt ====
# T name | B bubble | I instr_hex outcome a b
# outcome W: a=reg b=value, E: a=cause, N: no output
T rtype
I 3c018000 W 1 80000000
I 342100f0 W 1 800000f0
I 34020ff0 W 2 00000ff0
I 00221824 W 3 000000f0
I 00222025 W 4 80000ff0
I 00222826 W 5 80000f00
I 00223027 W 6 7ffff00f
I 00013900 W 7 00000f00
I 00014102 W 8 0800000f
I 00014903 W 9 f800000f
I 00415004 W 10 00f00000
I 00415806 W 11 00008000
I 00416007 W 12 ffff8000
I 0022682a W 13 00000001
I 0022702b W 14 00000000
I 0041782a W 15 00000000
I 0041802b W 16 00000001
T immediate
I 3031ffff W 17 000000f0
I 34128001 W 18 00008001
I 3833ffff W 19 8000ff0f
I 2414ffff W 20 ffffffff
I 24358000 W 21 7fff80f0
I 2856ffff W 22 00000000
I 2c57ffff W 23 00000001
I 28380001 W 24 00000001
I 3c191234 W 25 12340000
T forwarding
I 34010005 W 1 00000005
I 00211021 W 2 0000000a
I 00411821 W 3 0000000f
I 00232021 W 4 00000014
I 34050001 W 5 00000001
I 34050002 W 5 00000002
I 00a53021 W 6 00000004
I 34070007 W 7 00000007
B
I 00e74021 W 8 0000000e
B
B
I 01074821 W 9 00000015
I 340a0003 W 10 00000003
I 340b0004 W 11 00000004
I 014b6023 W 12 ffffffff
T overflow
I 3c017fff W 1 7fff0000
I 3421ffff W 1 7fffffff
I 34020001 W 2 00000001
I 3c038000 W 3 80000000
I 34041234 W 4 00001234
I 00222020 E 12 0
I 00802821 W 5 00001234
I 00223021 W 6 80000000
I 00622022 E 12 0
I 00623823 W 7 7fffffff
I 20240001 E 12 0
I 24280001 W 8 80000000
I 00804821 W 9 00001234
I 00425020 W 10 00000002
T reserved
I fc000000 E 10 0
I 0000003f E 10 0
I 8c010000 E 10 0
I 34000055 N 0 0
I 00210021 N 0 0
I 00005021 W 10 00000000
I 00015825 W 11 7fffffff
